// File: src/cpu_consts.svh
/* cpu constants
   widths, reset vector, major opcodes and function codes */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W      32
`define REG_IDX_W   5
`define RESET_PC    32'hbfc0_0000

// major opcodes, instr[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101

// special function codes, instr[5:0]
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

`endif

// File: src/cpu_pkg.sv
/* cpu types
   word and register index vectors, fsm and alu encodings, stage structs */
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI    // pass the shifted immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_ADDR,    // ar phase
        FETCH_DATA,    // r phase, keep the word
        FETCH_DROP     // r phase, discard the word
    } fetch_state_e;

    // fetch to bus
    typedef struct packed {
        logic  arvalid;
        word_t araddr;
        logic  rready;
    } rd_req_t;

    // bus to fetch
    typedef struct packed {
        logic  arready;
        logic  rvalid;
        word_t rdata;
    } rd_rsp_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;        // already extended
        logic     use_imm;
        logic     is_beq;
        logic     is_bne;
        reg_idx_t dst;
        logic     wr_en;
    } id_exe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t dst;
        logic     wr_en;
        word_t    result;
    } wb_t;

endpackage

// File: src/fetch_stage.sv
/* fetch stage
   pc, single-beat read channel fsm with stale-response drop, if/id register */
`include "cpu_consts.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    redirect,
    input  word_t   redirect_pc,
    output rd_req_t rd_req,
    input  rd_rsp_t rd_rsp,
    output if_id_t  if_id
);
    fetch_state_e state;
    word_t        pc;          // pc of the word in flight
    word_t        req_addr;    // held on ar until accepted
    word_t        next_pc;
    logic         ar_valid;
    logic         r_ready;
    logic         ar_hs;
    logic         r_hs;

    assign rd_req = '{arvalid: ar_valid, araddr: req_addr, rready: r_ready};

    assign ar_hs   = ar_valid & rd_rsp.arready;
    assign r_hs    = r_ready & rd_rsp.rvalid;
    assign next_pc = redirect ? redirect_pc : pc + 32'd4;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= FETCH_ADDR;
            pc       <= `RESET_PC;
            req_addr <= `RESET_PC;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else begin
            case (state)
                FETCH_ADDR: begin
                    ar_valid <= ~ar_hs;    // also the first raise after reset
                    r_ready  <= ar_hs;
                    if (redirect) begin
                        pc <= redirect_pc;
                        if (ar_valid) begin
                            state <= FETCH_DROP;    // address already offered
                        end else begin
                            req_addr <= redirect_pc;
                        end
                    end else if (ar_hs) begin
                        state <= FETCH_DATA;
                    end
                end
                FETCH_DATA: begin
                    if (r_hs) begin
                        state    <= FETCH_ADDR;
                        pc       <= next_pc;
                        req_addr <= next_pc;
                        ar_valid <= 1'b1;
                        r_ready  <= 1'b0;
                    end else if (redirect) begin
                        state <= FETCH_DROP;
                        pc    <= redirect_pc;
                    end
                end
                FETCH_DROP: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                    if (ar_hs) begin
                        ar_valid <= 1'b0;    // stale address taken, wait for its data
                        r_ready  <= 1'b1;
                    end else if (r_hs) begin
                        state    <= FETCH_ADDR;
                        req_addr <= redirect ? redirect_pc : pc;
                        ar_valid <= 1'b1;
                        r_ready  <= 1'b0;
                    end
                end
                default: begin
                    state <= FETCH_ADDR;
                end
            endcase
        end
    end

    // bubble unless a live word arrives this cycle
    always_ff @(posedge aclk) begin
        if_id.pc    <= pc;
        if_id.instr <= rd_rsp.rdata;
        if (!rst_n) begin
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= r_hs & (state == FETCH_DATA) & ~redirect;
        end
    end

endmodule

// File: src/decode_stage.sv
/* decode stage
   opcode and function decode, immediate extension, id/exe register */
`include "cpu_consts.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     squash,
    input  if_id_t   if_id,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output id_exe_t  id_exe
);
    word_t    instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t rd_idx;
    alu_op_e  alu_op;
    word_t    imm;
    logic     use_imm;
    logic     is_beq;
    logic     is_bne;
    reg_idx_t dst;
    logic     wr_en;

    assign instr  = if_id.instr;
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];

    always_comb begin
        alu_op  = ALU_ADD;
        imm     = {{16{instr[15]}}, instr[15:0]};    // sign extend by default
        use_imm = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        dst     = rt_idx;
        wr_en   = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                dst   = rd_idx;
                wr_en = 1'b1;
                case (funct)
                    `FN_ADDU: alu_op = ALU_ADD;
                    `FN_SUBU: alu_op = ALU_SUB;
                    `FN_AND:  alu_op = ALU_AND;
                    `FN_OR:   alu_op = ALU_OR;
                    `FN_SLT:  alu_op = ALU_SLT;
                    default:  wr_en  = 1'b0;    // unsupported, runs as nop
                endcase
            end
            `OP_ADDIU: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            `OP_ORI: begin
                alu_op  = ALU_OR;
                imm     = {16'h0000, instr[15:0]};
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            `OP_LUI: begin
                alu_op  = ALU_LUI;
                imm     = {instr[15:0], 16'h0000};
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            `OP_BEQ: is_beq = 1'b1;
            `OP_BNE: is_bne = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge aclk) begin
        id_exe.pc      <= if_id.pc;
        id_exe.alu_op  <= alu_op;
        id_exe.rs      <= rs_idx;
        id_exe.rt      <= rt_idx;
        id_exe.rs_val  <= rs_val;
        id_exe.rt_val  <= rt_val;
        id_exe.imm     <= imm;
        id_exe.use_imm <= use_imm;
        id_exe.is_beq  <= is_beq;
        id_exe.is_bne  <= is_bne;
        id_exe.dst     <= dst;
        id_exe.wr_en   <= wr_en;
        if (!rst_n) begin
            id_exe.valid <= 1'b0;
        end else begin
            id_exe.valid <= if_id.valid & ~squash;    // younger than a taken branch
        end
    end

endmodule

// File: src/reg_file.sv
/* register file
   32 words, r0 reads zero, same-cycle write data bypassed to the read ports */
module reg_file
    import cpu_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    input  wb_t      wb
);
    localparam int unsigned NUM_REGS = 2 ** $bits(reg_idx_t);

    word_t regs [NUM_REGS];
    logic  wr_hit;

    assign wr_hit = wb.valid & wb.wr_en & (wb.dst != '0);

    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_hit && (wb.dst == idx)) begin
            return wb.result;    // write-through
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb.dst] <= wb.result;
        end
    end

endmodule

// File: src/execute_stage.sv
/* execute stage
   operand forwarding from wb, alu, beq/bne resolution, exe/wb register */
`include "cpu_consts.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,
    input  id_exe_t id_exe,
    output logic    redirect,
    output word_t   redirect_pc,
    output wb_t     wb
);
    logic  fwd_rs;
    logic  fwd_rt;
    word_t op_a;
    word_t op_b;
    word_t src_b;
    word_t alu_res;
    logic  slt;
    logic  is_branch;
    logic  taken;

    // only wb can be ahead of exe
    assign fwd_rs = wb.valid & wb.wr_en & (wb.dst == id_exe.rs) & (id_exe.rs != '0);
    assign fwd_rt = wb.valid & wb.wr_en & (wb.dst == id_exe.rt) & (id_exe.rt != '0);

    assign op_a  = fwd_rs ? wb.result : id_exe.rs_val;
    assign op_b  = fwd_rt ? wb.result : id_exe.rt_val;
    assign src_b = id_exe.use_imm ? id_exe.imm : op_b;
    assign slt   = $signed(op_a) < $signed(src_b);

    always_comb begin
        case (id_exe.alu_op)
            ALU_ADD: alu_res = op_a + src_b;    // wraps, no overflow trap
            ALU_SUB: alu_res = op_a - src_b;
            ALU_AND: alu_res = op_a & src_b;
            ALU_OR:  alu_res = op_a | src_b;
            ALU_SLT: alu_res = {{(`WORD_W - 1){1'b0}}, slt};
            ALU_LUI: alu_res = src_b;
            default: alu_res = '0;
        endcase
    end

    // no delay slot, target relative to the branch itself
    assign is_branch   = id_exe.is_beq | id_exe.is_bne;
    assign taken       = (id_exe.is_beq & (op_a == op_b)) | (id_exe.is_bne & (op_a != op_b));
    assign redirect    = id_exe.valid & taken;
    assign redirect_pc = id_exe.pc + 32'd4 + {id_exe.imm[`WORD_W-3:0], 2'b00};

    always_ff @(posedge aclk) begin
        wb.pc     <= id_exe.pc;
        wb.dst    <= id_exe.dst;
        wb.wr_en  <= id_exe.wr_en & (id_exe.dst != '0);    // r0 writes vanish
        wb.result <= alu_res;
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= id_exe.valid & ~is_branch;
        end
    end

endmodule

// File: src/mycpu_top.sv
/* cpu top
   four-stage pipeline with an instruction read channel and golden-trace ports */
module mycpu_top
    import cpu_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    output word_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rvalid,
    output logic       rready,
    output word_t      debug_wb_pc,
    output word_t      debug_wb_rf_wdata,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum
);
    rd_req_t  rd_req;
    rd_rsp_t  rd_rsp;
    if_id_t   if_id;
    id_exe_t  id_exe;
    wb_t      wb;
    logic     redirect;      // taken branch in exe
    word_t    redirect_pc;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_val;
    word_t    rt_val;

    assign rd_rsp  = '{arready: arready, rvalid: rvalid, rdata: rdata};
    assign araddr  = rd_req.araddr;
    assign arvalid = rd_req.arvalid;
    assign rready  = rd_req.rready;

    // golden trace taps the exe/wb register
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wdata = wb.result;
    assign debug_wb_rf_wen   = (wb.valid && wb.wr_en) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum  = wb.dst;

    fetch_stage fetch_stage_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .if_id       (if_id)
    );

    decode_stage decode_stage_i (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .squash (redirect),
        .if_id  (if_id),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .id_exe (id_exe)
    );

    reg_file reg_file_i (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb     (wb)
    );

    execute_stage execute_stage_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .id_exe      (id_exe),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

endmodule

// File: dv/tb_program.svh
/* cpu test program and golden writeback trace
   alu ops, forwarding at distance one and two, r0 writes, taken and not-taken branches */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 22;

word_t prog_mem [PROG_LEN];

task automatic load_program();
    prog_mem[0]  = encode_i(`OP_LUI, 5'd0, 5'd1, 16'h1234);      // r1 = 1234_0000
    prog_mem[1]  = encode_i(`OP_ORI, 5'd1, 5'd1, 16'h5678);      // distance one on r1
    prog_mem[2]  = encode_i(`OP_ADDIU, 5'd0, 5'd2, 16'hffff);    // r2 = -1
    prog_mem[3]  = encode_r(5'd1, 5'd2, 5'd3, `FN_ADDU);         // r1 at distance two
    prog_mem[4]  = encode_r(5'd2, 5'd1, 5'd4, `FN_SUBU);
    prog_mem[5]  = encode_r(5'd1, 5'd3, 5'd5, `FN_AND);
    prog_mem[6]  = encode_r(5'd4, 5'd5, 5'd6, `FN_OR);
    prog_mem[7]  = encode_r(5'd2, 5'd1, 5'd7, `FN_SLT);          // -1 < positive
    prog_mem[8]  = encode_r(5'd1, 5'd2, 5'd8, `FN_SLT);
    prog_mem[9]  = encode_i(`OP_ADDIU, 5'd1, 5'd0, 16'h0005);    // r0 write, no trace
    prog_mem[10] = encode_r(5'd0, 5'd1, 5'd9, `FN_ADDU);         // r0 must read zero
    prog_mem[11] = encode_i(`OP_BEQ, 5'd9, 5'd1, 16'h0002);      // taken, to 14
    prog_mem[12] = encode_i(`OP_ADDIU, 5'd0, 5'd10, 16'h0111);   // squashed
    prog_mem[13] = encode_i(`OP_ADDIU, 5'd0, 5'd11, 16'h0222);   // squashed
    prog_mem[14] = encode_i(`OP_BNE, 5'd1, 5'd2, 16'h0002);      // taken, to 17
    prog_mem[15] = encode_i(`OP_ADDIU, 5'd0, 5'd10, 16'h0333);   // squashed
    prog_mem[16] = encode_i(`OP_ADDIU, 5'd0, 5'd11, 16'h0444);   // squashed
    prog_mem[17] = encode_i(`OP_BEQ, 5'd1, 5'd2, 16'h0005);      // not taken
    prog_mem[18] = encode_i(`OP_BNE, 5'd9, 5'd1, 16'h0005);      // not taken
    prog_mem[19] = encode_i(`OP_ADDIU, 5'd7, 5'd12, 16'h7fff);
    prog_mem[20] = encode_i(`OP_ADDIU, 5'd12, 5'd13, 16'hfff0);  // negative immediate
    prog_mem[21] = encode_i(`OP_ORI, 5'd0, 5'd14, 16'h8001);     // zero extended

    // pc, register, value
    expect_write(`RESET_PC + 32'h00, 5'd1, 32'h1234_0000);
    expect_write(`RESET_PC + 32'h04, 5'd1, 32'h1234_5678);
    expect_write(`RESET_PC + 32'h08, 5'd2, 32'hffff_ffff);
    expect_write(`RESET_PC + 32'h0c, 5'd3, 32'h1234_5677);
    expect_write(`RESET_PC + 32'h10, 5'd4, 32'hedcb_a987);
    expect_write(`RESET_PC + 32'h14, 5'd5, 32'h1234_5670);
    expect_write(`RESET_PC + 32'h18, 5'd6, 32'hffff_fff7);
    expect_write(`RESET_PC + 32'h1c, 5'd7, 32'h0000_0001);
    expect_write(`RESET_PC + 32'h20, 5'd8, 32'h0000_0000);
    expect_write(`RESET_PC + 32'h28, 5'd9, 32'h1234_5678);
    expect_write(`RESET_PC + 32'h4c, 5'd12, 32'h0000_8000);
    expect_write(`RESET_PC + 32'h50, 5'd13, 32'h0000_7ff0);
    expect_write(`RESET_PC + 32'h54, 5'd14, 32'h0000_8001);
endtask

`endif

// File: dv/tb_mycpu.sv
/* cpu testbench
   instruction memory with random read latency, golden writeback trace checker */
`include "cpu_consts.svh"

module tb_mycpu
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 200;    // cycles per wait loop
    localparam int QUIET_CYCLES = 40;

    typedef struct packed {
        word_t    pc;
        reg_idx_t wnum;
        word_t    wdata;
    } trace_entry_t;

    logic       aclk;
    logic       rst_n;
    word_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rvalid;
    logic       rready;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;

    trace_entry_t exp_trace [$];
    int           reads_served = 0;

    mycpu_top mycpu_top_i (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .araddr            (araddr),
        .arvalid           (arvalid),
        .arready           (arready),
        .rdata             (rdata),
        .rvalid            (rvalid),
        .rready            (rready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    function automatic word_t encode_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                       logic [5:0] funct);
        return {`OP_SPECIAL, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic word_t encode_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void expect_write(word_t pc, reg_idx_t wnum, word_t wdata);
        trace_entry_t entry;
        entry.pc    = pc;
        entry.wnum  = wnum;
        entry.wdata = wdata;
        exp_trace.push_back(entry);
    endfunction

    `include "tb_program.svh"

    function automatic word_t fetch_word(word_t addr);
        word_t offset;
        offset = addr - `RESET_PC;
        if (offset[1:0] != 2'b00 || offset >= 32'(4 * PROG_LEN)) begin
            return '0;    // outside the program, runs as a nop
        end
        return prog_mem[int'(offset[31:2])];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, want));
        end
    endtask

    // one ar/r transfer, dut outputs sampled mid-cycle
    task automatic serve_read();
        word_t addr;
        int    delay;
        int    cycles;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout while waiting for a fetch request on arvalid");
            end
        end while (arvalid !== 1'b1);
        addr = araddr;
        if (reads_served == 0) begin
            check_equal("araddr", addr, `RESET_PC);
        end
        reads_served++;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
            @(posedge aclk);
        end
        @(posedge aclk);
        #1;
        arready = 1'b1;
        @(posedge aclk);    // address handshake, arvalid is held
        #1;
        arready = 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
            @(posedge aclk);
            #1;
        end
        rvalid = 1'b1;
        rdata  = fetch_word(addr);
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout while waiting for rready to take the fetch data");
            end
        end while (rready !== 1'b1);
        @(posedge aclk);    // data handshake
        #1;
        rvalid = 1'b0;
        rdata  = '0;
    endtask

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_HALF) aclk = ~aclk;
        end
    end

    initial begin : mem_model
        void'($urandom(32'h1dc9));
        forever begin
            serve_read();
        end
    end

    initial begin : main_seq
        trace_entry_t want;
        int           cycles;
        int           extra;
        rst_n   = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        load_program();
        repeat (RESET_CYCLES) @(posedge aclk);
        check_equal("arvalid", 32'(arvalid), 32'd0);
        check_equal("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'd0);
        #1;
        rst_n = 1'b1;

        foreach (exp_trace[i]) begin
            want   = exp_trace[i];
            cycles = 0;
            do begin
                @(negedge aclk);    // trace ports settled
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    abort_run($sformatf("timeout while waiting for writeback number %0d", i));
                end
            end while (debug_wb_rf_wen == 4'h0);
            check_equal("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0000_000f);
            check_equal("debug_wb_pc", debug_wb_pc, want.pc);
            check_equal("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(want.wnum));
            check_equal("debug_wb_rf_wdata", debug_wb_rf_wdata, want.wdata);
        end

        // squashed or r0 writes would show up here
        extra = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge aclk);
            if (debug_wb_rf_wen != 4'h0) begin
                extra++;
            end
        end
        if (extra != 0) begin
            abort_run($sformatf("%0d writebacks seen after the last expected one", extra));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+src
+incdir+dv
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/mycpu_top.sv
dv/tb_mycpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cpu testbench with verilator, run it, judge the run from its log

cd "$(dirname "$0")" || exit 1

TOP=tb_mycpu
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f filelist.f \
    && ./obj_dir/V"$TOP" > "$LOG" 2>&1 \
    || echo "build or simulation returned an error"

grep -qx "TEST OK" "$LOG" && echo "simulation passed" \
    || { tail -n 20 "$LOG"; echo "simulation failed"; exit 1; }
